// ==== all.f ====
verilog/mem_unit_pkg.sv
verilog/core_bus_if.sv
verilog/smem_switch.sv
verilog/socket_arb.sv
verilog/shared_mem.sv
verilog/mem_perf.sv
verilog/mem_unit.sv
tests/mem_unit_assertions.sv
tests/mem_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_unit_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmem_unit_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== tests/mem_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_unit_tb import mem_unit_pkg::*; ();

    localparam int RAND_SEED   = 32'h9b0d_a7a1;
    localparam int RUN_CYCLES  = 3000;
    localparam int STALL_LIMIT = 200;
    localparam int DRAIN_LIMIT = 2000;
    localparam int MAX_DELAY   = 6;

    typedef struct {
        word_t    data;
        arb_tag_t tag;
        int       due;
    } ext_rsp_t;

    logic  clk;
    logic  reset;
    logic  req_valid [NUM_SOCKETS];
    logic  req_rw [NUM_SOCKETS];
    addr_t req_addr [NUM_SOCKETS];
    byteen_t req_byteen [NUM_SOCKETS];
    word_t req_data [NUM_SOCKETS];
    tag_t  req_tag [NUM_SOCKETS];
    logic  rsp_ready [NUM_SOCKETS];
    wire   req_ready [NUM_SOCKETS];
    wire   rsp_valid [NUM_SOCKETS];
    wire word_t rsp_data [NUM_SOCKETS];
    wire tag_t  rsp_tag [NUM_SOCKETS];

    logic     mem_req_ready;
    logic     mem_rsp_valid;
    word_t    mem_rsp_data;
    arb_tag_t mem_rsp_tag;
    wire      mem_req_valid;
    wire      mem_req_rw;
    wire      mem_rsp_ready;
    wire addr_t    mem_req_addr;
    wire byteen_t  mem_req_byteen;
    wire word_t    mem_req_data;
    wire arb_tag_t mem_req_tag;
    wire perf_count_t mem_reads;
    wire perf_count_t mem_writes;
    wire perf_count_t mem_latency;

    // Reference state
    word_t smem_ref [2 ** SMEM_ADDR_WIDTH];
    logic  smem_written [2 ** SMEM_ADDR_WIDTH];
    word_t glob_ref [addr_t];
    word_t ext_mem [addr_t];
    logic  busy [NUM_SOCKETS][16];
    logic  from_smem [NUM_SOCKETS][16];
    word_t expected [NUM_SOCKETS][16];
    logic  accepted [NUM_SOCKETS];
    int    stall [NUM_SOCKETS];
    ext_rsp_t rsp_queue [$];

    perf_count_t reads_model;
    perf_count_t writes_model;
    perf_count_t latency_model;
    perf_count_t pending_model;
    int cycle_count;
    int smem_reads_seen;
    int glob_reads_seen;
    bit stim_on;

    mem_unit dut (
        .clk              (clk),
        .reset            (reset),
        .core0_req_valid  (req_valid[0]),
        .core0_req_rw     (req_rw[0]),
        .core0_req_addr   (req_addr[0]),
        .core0_req_byteen (req_byteen[0]),
        .core0_req_data   (req_data[0]),
        .core0_req_tag    (req_tag[0]),
        .core0_req_ready  (req_ready[0]),
        .core0_rsp_valid  (rsp_valid[0]),
        .core0_rsp_data   (rsp_data[0]),
        .core0_rsp_tag    (rsp_tag[0]),
        .core0_rsp_ready  (rsp_ready[0]),
        .core1_req_valid  (req_valid[1]),
        .core1_req_rw     (req_rw[1]),
        .core1_req_addr   (req_addr[1]),
        .core1_req_byteen (req_byteen[1]),
        .core1_req_data   (req_data[1]),
        .core1_req_tag    (req_tag[1]),
        .core1_req_ready  (req_ready[1]),
        .core1_rsp_valid  (rsp_valid[1]),
        .core1_rsp_data   (rsp_data[1]),
        .core1_rsp_tag    (rsp_tag[1]),
        .core1_rsp_ready  (rsp_ready[1]),
        .mem_req_valid    (mem_req_valid),
        .mem_req_rw       (mem_req_rw),
        .mem_req_addr     (mem_req_addr),
        .mem_req_byteen   (mem_req_byteen),
        .mem_req_data     (mem_req_data),
        .mem_req_tag      (mem_req_tag),
        .mem_req_ready    (mem_req_ready),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_data     (mem_rsp_data),
        .mem_rsp_tag      (mem_rsp_tag),
        .mem_rsp_ready    (mem_rsp_ready),
        .mem_reads        (mem_reads),
        .mem_writes       (mem_writes),
        .mem_latency      (mem_latency)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_tag(input tag_t got, input tag_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_count(input perf_count_t got, input perf_count_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    // Unwritten external words read back a pattern of their address
    function automatic word_t fill_word(input addr_t a);
        return {a[7:0], a[31:8]} ^ 32'h6d2b_79f5;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input byteen_t be);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) w[b*8 +: 8] = data[b*8 +: 8];
        end
        return w;
    endfunction

    // Thread in address bits 13..12 selects a 64-word stack slice
    function automatic smem_addr_t smem_index(input addr_t a);
        return smem_addr_t'(a[13:12] * 64 + a[7:2]);
    endfunction

    task automatic accept_request(input int s);
        addr_t a;
        smem_addr_t idx;
        word_t old;
        a = req_addr[s];
        if (a[31:24] == SMEM_BASE_TOP) begin
            idx = smem_index(a);
            old = smem_ref[idx];
            if (req_rw[s]) begin
                smem_ref[idx] = merge_bytes(old, req_data[s], req_byteen[s]);
                smem_written[idx] = 1'b1;
            end
        end else begin
            old = glob_ref.exists(a) ? glob_ref[a] : fill_word(a);
            if (req_rw[s]) glob_ref[a] = merge_bytes(old, req_data[s], req_byteen[s]);
        end
        if (!req_rw[s]) begin
            busy[s][req_tag[s]] = 1'b1;
            from_smem[s][req_tag[s]] = (a[31:24] == SMEM_BASE_TOP);
            expected[s][req_tag[s]] = old;
        end
        stall[s] = 0;
    endtask

    task automatic check_response(input int s);
        tag_t t;
        t = rsp_tag[s];
        if (!busy[s][t]) begin
            report_mismatch($sformatf("socket %0d response with tag %h and no read", s, t));
        end
        check_word(rsp_data[s], expected[s][t], $sformatf("socket %0d read data", s));
        if (from_smem[s][t]) smem_reads_seen++;
        else glob_reads_seen++;
        busy[s][t] = 1'b0;
    endtask

    task automatic sample_ports();
        int glob_fires;
        int glob_socket;
        logic mem_fire;
        ext_rsp_t entry;
        word_t old;
        glob_fires = 0;
        glob_socket = 0;
        for (int s = 0; s < NUM_SOCKETS; s++) begin
            if (rsp_valid[s] && rsp_ready[s]) check_response(s);
            accepted[s] = req_valid[s] && req_ready[s];
            if (accepted[s]) begin
                accept_request(s);
                if (req_addr[s][31:24] != SMEM_BASE_TOP) begin
                    glob_fires++;
                    glob_socket = s;
                end
            end
        end

        // Global accepts and external accepts happen in the same cycle
        mem_fire = mem_req_valid && mem_req_ready;
        if (glob_fires != int'(mem_fire)) begin
            report_mismatch($sformatf("%0d external accepts for %0d global accepts",
                                      mem_fire, glob_fires));
        end
        latency_model += pending_model;
        if (mem_fire) begin
            if (mem_req_tag[0] !== glob_socket[0] || mem_req_addr !== req_addr[glob_socket]
                    || mem_req_rw !== req_rw[glob_socket]
                    || mem_req_byteen !== req_byteen[glob_socket]) begin
                report_mismatch("external request does not match the socket request");
            end
            check_tag(mem_req_tag[ARB_TAG_WIDTH-1:1], req_tag[glob_socket], "external tag");
            old = ext_mem.exists(mem_req_addr) ? ext_mem[mem_req_addr] : fill_word(mem_req_addr);
            if (mem_req_rw) begin
                check_word(mem_req_data, req_data[glob_socket], "external write data");
                ext_mem[mem_req_addr] = merge_bytes(old, mem_req_data, mem_req_byteen);
                writes_model++;
            end else begin
                entry.data = old;
                entry.tag  = mem_req_tag;
                entry.due  = cycle_count + 1 + $urandom_range(MAX_DELAY);
                rsp_queue.push_back(entry);
                reads_model++;
                pending_model++;
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            rsp_queue.delete(0);
            pending_model--;
        end
    endtask

    task automatic new_request(input int s);
        int t0;
        int t;
        logic found;
        logic wr;
        byteen_t be;
        addr_t a;
        found = 1'b0;
        t = 0;
        t0 = $urandom_range(15);
        for (int k = 0; k < 16; k++) begin
            if (!found && !busy[s][(t0 + k) % 16]) begin
                t = (t0 + k) % 16;
                found = 1'b1;
            end
        end
        wr = 1'($urandom_range(1));
        be = byteen_t'($urandom);
        if ($urandom_range(1) == 1) begin
            a = {SMEM_BASE_TOP, 10'($urandom), 1'(s), 1'($urandom), 4'($urandom),
                 6'($urandom), 2'b00};
            // First touch of a scratchpad word is a full write
            if (!smem_written[smem_index(a)]) begin
                wr = 1'b1;
                be = '1;
            end
        end else begin
            a = 32'h0000_2000 + s * 32'h100 + 4 * $urandom_range(7);
        end
        req_valid[s]  <= found;
        req_rw[s]     <= wr;
        req_addr[s]   <= a;
        req_byteen[s] <= be;
        req_data[s]   <= word_t'($urandom);
        req_tag[s]    <= tag_t'(t);
    endtask

    task automatic drive_inputs();
        for (int s = 0; s < NUM_SOCKETS; s++) begin
            if (req_valid[s] && !accepted[s]) begin
                stall[s]++;
                if (stall[s] > STALL_LIMIT) begin
                    $display("Socket %0d request was not accepted in %0d cycles", s, STALL_LIMIT);
                    stop_with_failure();
                end
            end else if (stim_on && $urandom_range(3) != 0) begin
                new_request(s);
            end else begin
                req_valid[s] <= 1'b0;
            end
            rsp_ready[s] <= ($urandom_range(3) != 0);
        end
        mem_req_ready <= ($urandom_range(2) != 0);
        if (!mem_rsp_valid || mem_rsp_ready) begin
            if (rsp_queue.size() > 0 && rsp_queue[0].due <= cycle_count) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= rsp_queue[0].data;
                mem_rsp_tag   <= rsp_queue[0].tag;
            end else begin
                mem_rsp_valid <= 1'b0;
            end
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        cycle_count++;
        sample_ports();
        drive_inputs();
    endtask

    function automatic logic traffic_idle();
        logic idle;
        idle = (rsp_queue.size() == 0) && !mem_rsp_valid;
        for (int s = 0; s < NUM_SOCKETS; s++) begin
            idle &= !req_valid[s];
            for (int t = 0; t < 16; t++) idle &= !busy[s][t];
        end
        return idle;
    endfunction

    initial begin
        int wait_count;
        void'($urandom(RAND_SEED));
        clk = 1'b0;
        reset = 1'b1;
        for (int s = 0; s < NUM_SOCKETS; s++) begin
            req_valid[s] = 1'b0;
            req_rw[s] = 1'b0;
            req_addr[s] = '0;
            req_byteen[s] = '0;
            req_data[s] = '0;
            req_tag[s] = '0;
            rsp_ready[s] = 1'b0;
            accepted[s] = 1'b0;
            stall[s] = 0;
            for (int t = 0; t < 16; t++) busy[s][t] = 1'b0;
        end
        for (int i = 0; i < 2 ** SMEM_ADDR_WIDTH; i++) smem_written[i] = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        mem_rsp_tag = '0;
        reads_model = '0;
        writes_model = '0;
        latency_model = '0;
        pending_model = '0;
        cycle_count = 0;
        smem_reads_seen = 0;
        glob_reads_seen = 0;

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        stim_on = 1'b1;
        repeat (RUN_CYCLES) run_cycle();
        stim_on = 1'b0;

        wait_count = 0;
        while (!traffic_idle()) begin
            if (wait_count == DRAIN_LIMIT) begin
                $display("Outstanding traffic did not drain within %0d cycles", DRAIN_LIMIT);
                stop_with_failure();
            end
            run_cycle();
            wait_count++;
        end
        repeat (4) run_cycle();

        @(negedge clk);
        check_count(mem_reads, reads_model, "mem_reads");
        check_count(mem_writes, writes_model, "mem_writes");
        check_count(mem_latency, latency_model, "mem_latency");
        if (smem_reads_seen == 0 || glob_reads_seen == 0) begin
            $display("Run finished without reads on both paths");
            stop_with_failure();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/mem_unit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module arb_handshake_checks import mem_unit_pkg::*; (
    input wire                   clk,
    input wire                   reset,
    input wire                   req_valid,
    input wire                   req_ready,
    input wire arb_tag_t         req_tag,
    input wire addr_t            req_addr,
    input wire                   rsp_valid,
    input wire [NUM_SOCKETS-1:0] socket_valid
);

    logic [SOCKET_BITS-1:0] grant;

    assign grant = req_tag[SOCKET_BITS-1:0];

    // A stalled request keeps valid and payload
    assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req_tag) && $stable(req_addr))
        else $error("arbiter request changed while stalled");

    // With both sockets waiting, the low tag bit moves on after an accept
    assert property (@(posedge clk) disable iff (reset)
        req_valid && req_ready && (&socket_valid) |=>
            !(&socket_valid) || (grant != $past(grant)))
        else $error("forwarded tag names the socket that was just accepted");

    assert property (@(posedge clk) reset |=> !req_valid && !rsp_valid)
        else $error("arbiter outputs active right after reset");

endmodule

bind socket_arb arb_handshake_checks arb_checks (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (out.req_valid),
    .req_ready    (out.req_ready),
    .req_tag      (out.req_tag),
    .req_addr     (out.req_addr),
    .rsp_valid    (out.rsp_valid),
    .socket_valid (req_valid)
);

`default_nettype wire

// ==== verilog/mem_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_unit import mem_unit_pkg::*; (
    input wire          clk,
    input wire          reset,

    input wire          core0_req_valid,
    input wire          core0_req_rw,
    input wire addr_t   core0_req_addr,
    input wire byteen_t core0_req_byteen,
    input wire word_t   core0_req_data,
    input wire tag_t    core0_req_tag,
    output logic        core0_req_ready,
    output logic        core0_rsp_valid,
    output word_t       core0_rsp_data,
    output tag_t        core0_rsp_tag,
    input wire          core0_rsp_ready,

    input wire          core1_req_valid,
    input wire          core1_req_rw,
    input wire addr_t   core1_req_addr,
    input wire byteen_t core1_req_byteen,
    input wire word_t   core1_req_data,
    input wire tag_t    core1_req_tag,
    output logic        core1_req_ready,
    output logic        core1_rsp_valid,
    output word_t       core1_rsp_data,
    output tag_t        core1_rsp_tag,
    input wire          core1_rsp_ready,

    output logic        mem_req_valid,
    output logic        mem_req_rw,
    output addr_t       mem_req_addr,
    output byteen_t     mem_req_byteen,
    output word_t       mem_req_data,
    output arb_tag_t    mem_req_tag,
    input wire          mem_req_ready,
    input wire          mem_rsp_valid,
    input wire word_t   mem_rsp_data,
    input wire arb_tag_t mem_rsp_tag,
    output logic        mem_rsp_ready,

    output perf_count_t mem_reads,
    output perf_count_t mem_writes,
    output perf_count_t mem_latency
);

    core_bus_if #(.TAG_BITS(TAG_WIDTH))     core_bus [NUM_SOCKETS] ();
    core_bus_if #(.TAG_BITS(TAG_WIDTH))     smem_bus [NUM_SOCKETS] ();
    core_bus_if #(.TAG_BITS(TAG_WIDTH))     glob_bus [NUM_SOCKETS] ();
    core_bus_if #(.TAG_BITS(ARB_TAG_WIDTH)) smem_out ();
    core_bus_if #(.TAG_BITS(ARB_TAG_WIDTH)) glob_out ();

    assign core_bus[0].req_valid  = core0_req_valid;
    assign core_bus[0].req_rw     = core0_req_rw;
    assign core_bus[0].req_addr   = core0_req_addr;
    assign core_bus[0].req_byteen = core0_req_byteen;
    assign core_bus[0].req_data   = core0_req_data;
    assign core_bus[0].req_tag    = core0_req_tag;
    assign core_bus[0].rsp_ready  = core0_rsp_ready;
    assign core0_req_ready        = core_bus[0].req_ready;
    assign core0_rsp_valid        = core_bus[0].rsp_valid;
    assign core0_rsp_data         = core_bus[0].rsp_data;
    assign core0_rsp_tag          = core_bus[0].rsp_tag;

    assign core_bus[1].req_valid  = core1_req_valid;
    assign core_bus[1].req_rw     = core1_req_rw;
    assign core_bus[1].req_addr   = core1_req_addr;
    assign core_bus[1].req_byteen = core1_req_byteen;
    assign core_bus[1].req_data   = core1_req_data;
    assign core_bus[1].req_tag    = core1_req_tag;
    assign core_bus[1].rsp_ready  = core1_rsp_ready;
    assign core1_req_ready        = core_bus[1].req_ready;
    assign core1_rsp_valid        = core_bus[1].rsp_valid;
    assign core1_rsp_data         = core_bus[1].rsp_data;
    assign core1_rsp_tag          = core_bus[1].rsp_tag;

    for (genvar i = 0; i < NUM_SOCKETS; i++) begin : g_switch
        smem_switch socket_switch (
            .clk   (clk),
            .reset (reset),
            .core  (core_bus[i]),
            .smem  (smem_bus[i]),
            .glob  (glob_bus[i])
        );
    end

    socket_arb smem_arb (
        .clk   (clk),
        .reset (reset),
        .ins   (smem_bus),
        .out   (smem_out)
    );

    shared_mem smem (
        .clk   (clk),
        .reset (reset),
        .bus   (smem_out)
    );

    socket_arb glob_arb (
        .clk   (clk),
        .reset (reset),
        .ins   (glob_bus),
        .out   (glob_out)
    );

    // External memory port
    assign mem_req_valid        = glob_out.req_valid;
    assign mem_req_rw           = glob_out.req_rw;
    assign mem_req_addr         = glob_out.req_addr;
    assign mem_req_byteen       = glob_out.req_byteen;
    assign mem_req_data         = glob_out.req_data;
    assign mem_req_tag          = glob_out.req_tag;
    assign glob_out.req_ready   = mem_req_ready;
    assign glob_out.rsp_valid   = mem_rsp_valid;
    assign glob_out.rsp_data    = mem_rsp_data;
    assign glob_out.rsp_tag     = mem_rsp_tag;
    assign mem_rsp_ready        = glob_out.rsp_ready;

    mem_perf perf (
        .clk          (clk),
        .reset        (reset),
        .mem_req_fire (mem_req_valid && mem_req_ready),
        .mem_req_rw   (mem_req_rw),
        .mem_rsp_fire (mem_rsp_valid && mem_rsp_ready),
        .mem_reads    (mem_reads),
        .mem_writes   (mem_writes),
        .mem_latency  (mem_latency)
    );

endmodule

`default_nettype wire

// ==== verilog/mem_perf.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_perf import mem_unit_pkg::*; (
    input wire          clk,
    input wire          reset,
    input wire          mem_req_fire,
    input wire          mem_req_rw,
    input wire          mem_rsp_fire,
    output perf_count_t mem_reads,
    output perf_count_t mem_writes,
    output perf_count_t mem_latency
);

    logic        read_fire;
    logic        write_fire;
    perf_count_t pending;

    assign read_fire  = mem_req_fire && !mem_req_rw;
    assign write_fire = mem_req_fire && mem_req_rw;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending     <= '0;
            mem_reads   <= '0;
            mem_writes  <= '0;
            mem_latency <= '0;
        end else begin
            // Read issued and read returned in one cycle cancel out
            if (read_fire && !mem_rsp_fire) begin
                pending <= pending + 1'b1;
            end else if (mem_rsp_fire && !read_fire) begin
                pending <= pending - 1'b1;
            end
            if (read_fire) begin
                mem_reads <= mem_reads + 1'b1;
            end
            if (write_fire) begin
                mem_writes <= mem_writes + 1'b1;
            end
            mem_latency <= mem_latency + pending;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/shared_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_mem import mem_unit_pkg::*; (
    input wire            clk,
    input wire            reset,
    core_bus_if.responder bus
);

    localparam int SMEM_WORDS = 2 ** SMEM_ADDR_WIDTH;

    smem_addr_t req_idx;
    logic       req_fire;
    logic       rd_fire;
    logic       wr_fire;

    word_t      mem [SMEM_WORDS];

    logic       rsp_valid_r;
    word_t      rsp_data_r;
    arb_tag_t   rsp_tag_r;

    // Thread index above word index, so each thread's stack is contiguous
    assign req_idx = {bus.req_addr[STACK_OFFSET_BITS +: THREAD_BITS],
                      bus.req_addr[2 +: WORD_SEL_BITS]};

    // Full response register that is not draining blocks new requests
    assign bus.req_ready = !rsp_valid_r || bus.rsp_ready;

    assign req_fire = bus.req_valid && bus.req_ready;
    assign rd_fire  = req_fire && !bus.req_rw;
    assign wr_fire  = req_fire && bus.req_rw;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < BYTE_COUNT; b++) begin
                if (bus.req_byteen[b]) begin
                    mem[req_idx][b*8 +: 8] <= bus.req_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_data_r <= mem[req_idx];
            rsp_tag_r  <= bus.req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_r <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid_r <= 1'b1;
        end else if (bus.rsp_ready) begin
            rsp_valid_r <= 1'b0;
        end
    end

    assign bus.rsp_valid = rsp_valid_r;
    assign bus.rsp_data  = rsp_data_r;
    assign bus.rsp_tag   = rsp_tag_r;

endmodule

`default_nettype wire

// ==== verilog/socket_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module socket_arb import mem_unit_pkg::*; (
    input wire            clk,
    input wire            reset,
    core_bus_if.responder ins [NUM_SOCKETS],
    core_bus_if.requester out
);

    logic [NUM_SOCKETS-1:0] req_valid;
    logic [NUM_SOCKETS-1:0] req_rw;
    addr_t                  req_addr [NUM_SOCKETS];
    byteen_t                req_byteen [NUM_SOCKETS];
    word_t                  req_data [NUM_SOCKETS];
    tag_t                   req_tag [NUM_SOCKETS];
    logic [NUM_SOCKETS-1:0] rsp_ready;

    logic [SOCKET_BITS-1:0] last_grant;
    logic [SOCKET_BITS-1:0] rr_sel;
    logic [SOCKET_BITS-1:0] cand;
    logic [SOCKET_BITS-1:0] sel;
    logic [SOCKET_BITS-1:0] held_sel;
    logic [SOCKET_BITS-1:0] rsp_sel;
    logic                   found;
    logic                   hold;

    assign rsp_sel = out.rsp_tag[SOCKET_BITS-1:0];

    for (genvar i = 0; i < NUM_SOCKETS; i++) begin : g_socket
        assign req_valid[i]  = ins[i].req_valid;
        assign req_rw[i]     = ins[i].req_rw;
        assign req_addr[i]   = ins[i].req_addr;
        assign req_byteen[i] = ins[i].req_byteen;
        assign req_data[i]   = ins[i].req_data;
        assign req_tag[i]    = ins[i].req_tag;
        assign rsp_ready[i]  = ins[i].rsp_ready;

        assign ins[i].req_ready = out.req_ready && (sel == SOCKET_BITS'(i));

        // Response goes back to the socket named by the low tag bit
        assign ins[i].rsp_valid = out.rsp_valid && (rsp_sel == SOCKET_BITS'(i));
        assign ins[i].rsp_data  = out.rsp_data;
        assign ins[i].rsp_tag   = out.rsp_tag[ARB_TAG_WIDTH-1:SOCKET_BITS];
    end

    // Search starts at the socket after the last one accepted
    always_comb begin
        rr_sel = last_grant;
        cand   = last_grant;
        found  = 1'b0;
        for (int k = 1; k <= NUM_SOCKETS; k++) begin
            cand = SOCKET_BITS'((int'(last_grant) + k) % NUM_SOCKETS);
            if (!found && req_valid[cand]) begin
                rr_sel = cand;
                found  = 1'b1;
            end
        end
    end

    // A stalled grant stays put so the forwarded request holds
    assign sel = hold ? held_sel : rr_sel;

    assign out.req_valid  = req_valid[sel];
    assign out.req_rw     = req_rw[sel];
    assign out.req_addr   = req_addr[sel];
    assign out.req_byteen = req_byteen[sel];
    assign out.req_data   = req_data[sel];
    assign out.req_tag    = {req_tag[sel], sel};
    assign out.rsp_ready  = rsp_ready[rsp_sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= SOCKET_BITS'(NUM_SOCKETS - 1);
            hold       <= 1'b0;
            held_sel   <= '0;
        end else begin
            hold     <= out.req_valid && !out.req_ready;
            held_sel <= sel;
            if (out.req_valid && out.req_ready) begin
                last_grant <= sel;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/smem_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

module smem_switch import mem_unit_pkg::*; (
    input wire            clk,
    input wire            reset,
    core_bus_if.responder core,
    core_bus_if.requester smem,
    core_bus_if.requester glob
);

    logic is_smem;
    logic pick_glob;
    logic last_smem;
    logic rsp_fire;

    assign is_smem = (core.req_addr[31:24] == SMEM_BASE_TOP);

    // Payload fans out to both paths, valid only to the selected one
    assign smem.req_valid  = core.req_valid && is_smem;
    assign smem.req_rw     = core.req_rw;
    assign smem.req_addr   = core.req_addr;
    assign smem.req_byteen = core.req_byteen;
    assign smem.req_data   = core.req_data;
    assign smem.req_tag    = core.req_tag;

    assign glob.req_valid  = core.req_valid && !is_smem;
    assign glob.req_rw     = core.req_rw;
    assign glob.req_addr   = core.req_addr;
    assign glob.req_byteen = core.req_byteen;
    assign glob.req_data   = core.req_data;
    assign glob.req_tag    = core.req_tag;

    assign core.req_ready = is_smem ? smem.req_ready : glob.req_ready;

    // Shared memory wins a collision unless global was just passed over
    assign pick_glob = glob.rsp_valid && (!smem.rsp_valid || last_smem);

    assign core.rsp_valid = smem.rsp_valid || glob.rsp_valid;
    assign core.rsp_data  = pick_glob ? glob.rsp_data : smem.rsp_data;
    assign core.rsp_tag   = pick_glob ? glob.rsp_tag : smem.rsp_tag;

    assign smem.rsp_ready = core.rsp_ready && !pick_glob;
    assign glob.rsp_ready = core.rsp_ready && pick_glob;

    assign rsp_fire = core.rsp_valid && core.rsp_ready;

    // Set when shared memory went ahead of a waiting global response.
    // While the core stalls, the current winner is kept so the output holds.
    always_ff @(posedge clk) begin
        if (reset) begin
            last_smem <= 1'b0;
        end else if (rsp_fire) begin
            last_smem <= !pick_glob && glob.rsp_valid;
        end else if (core.rsp_valid) begin
            last_smem <= pick_glob;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/core_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface core_bus_if import mem_unit_pkg::*; #(
    parameter int TAG_BITS = TAG_WIDTH
);

    logic                req_valid;
    logic                req_rw;
    addr_t               req_addr;
    byteen_t             req_byteen;
    word_t               req_data;
    logic [TAG_BITS-1:0] req_tag;
    logic                req_ready;

    // Read responses only
    logic                rsp_valid;
    word_t               rsp_data;
    logic [TAG_BITS-1:0] rsp_tag;
    logic                rsp_ready;

    modport requester (
        output req_valid,
        output req_rw,
        output req_addr,
        output req_byteen,
        output req_data,
        output req_tag,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data,
        input  rsp_tag,
        output rsp_ready
    );

    modport responder (
        input  req_valid,
        input  req_rw,
        input  req_addr,
        input  req_byteen,
        input  req_data,
        input  req_tag,
        output req_ready,
        output rsp_valid,
        output rsp_data,
        output rsp_tag,
        input  rsp_ready
    );

endinterface

`default_nettype wire

// ==== verilog/mem_unit_pkg.sv ====
`default_nettype none

package mem_unit_pkg;

    // Core sockets sharing the memory unit
    localparam int NUM_SOCKETS = 2;
    localparam int SOCKET_BITS = 1;

    // Core tag, then widened by the socket index in the low bit
    localparam int TAG_WIDTH     = 4;
    localparam int ARB_TAG_WIDTH = TAG_WIDTH + SOCKET_BITS;

    // Address bits 31..24 equal to this select the shared-memory window
    localparam logic [7:0] SMEM_BASE_TOP = 8'hFF;

    // Stack interleaving of the scratchpad
    localparam int STACK_OFFSET_BITS = 12;
    localparam int WORD_SEL_BITS     = 6;
    localparam int THREAD_BITS       = 2;
    localparam int SMEM_ADDR_WIDTH   = THREAD_BITS + WORD_SEL_BITS;

    localparam int WORD_BITS  = 32;
    localparam int BYTE_COUNT = WORD_BITS / 8;

    typedef logic [WORD_BITS-1:0]       word_t;
    typedef logic [31:0]                addr_t;
    typedef logic [BYTE_COUNT-1:0]      byteen_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;
    typedef logic [ARB_TAG_WIDTH-1:0]   arb_tag_t;
    typedef logic [SMEM_ADDR_WIDTH-1:0] smem_addr_t;
    typedef logic [31:0]                perf_count_t;

endpackage

`default_nettype wire
